// File: compile.f
source/noc_router_pkg.sv
source/noc_router_fifo.sv
source/noc_router_input.sv
source/noc_router_output.sv
source/noc_router.sv
bench/noc_router_asserts.sv
bench/noc_router_checker.sv
bench/noc_router_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := noc_router_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/noc_router_golden.txt
# test src dst_x dst_y tag exp_out n_payload payload0 payload1 payload2 payload3
# Router at (1,1); ports 0 local 1 north 2 east 3 south 4 west; tag, payload in hex
2 0 1 1 10 0 0 00000000 00000000 00000000 00000000
2 0 1 0 10 1 0 00000000 00000000 00000000 00000000
2 0 2 1 10 2 0 00000000 00000000 00000000 00000000
2 0 1 2 10 3 0 00000000 00000000 00000000 00000000
2 0 0 1 10 4 0 00000000 00000000 00000000 00000000
3 1 1 3 11 3 3 31000001 31000002 31000003 00000000
3 2 0 2 12 4 4 32000001 32000002 32000003 32000004
3 4 3 0 14 2 2 34000001 34000002 00000000 00000000
3 3 1 0 13 1 3 33000001 33000002 33000003 00000000
3 0 1 1 10 0 2 30000001 30000002 00000000 00000000
4 0 3 1 10 2 2 40000001 40000002 00000000 00000000
4 1 2 2 11 2 3 41000001 41000002 41000003 00000000
4 3 3 3 13 2 1 43000001 00000000 00000000 00000000
4 0 2 0 10 2 1 40000011 00000000 00000000 00000000
4 1 3 1 11 2 4 41000011 41000012 41000013 41000014
4 4 2 1 14 2 2 44000001 44000002 00000000 00000000
5 0 3 1 10 2 4 50000001 50000002 50000003 50000004
5 1 3 2 11 2 3 51000001 51000002 51000003 00000000
5 2 1 3 12 3 4 52000001 52000002 52000003 52000004
5 3 3 0 13 2 2 53000001 53000002 00000000 00000000
5 4 1 0 14 1 4 54000001 54000002 54000003 54000004
5 0 1 3 10 3 2 50000011 50000012 00000000 00000000
5 1 0 1 11 4 4 51000011 51000012 51000013 51000014
5 2 3 3 12 2 4 52000011 52000012 52000013 52000014
5 3 1 1 13 0 3 53000011 53000012 53000013 00000000
5 4 2 1 14 2 3 54000011 54000012 54000013 00000000

// File: bench/noc_router_tb.sv
/*
  Testbench for the five-port router placed at mesh position (1,1).
  Packets and their expected output ports come from the golden file,
  opened relative to the project root. Random out_ready only in test 5.
  Every wait has a cycle limit, and a timeout ends the run.
*/
module noc_router_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int nports      = noc_router_pkg::num_ports;
  localparam int max_pkts    = 32;
  localparam int max_pay     = 4;
  localparam int wait_limit  = 500;
  localparam int drain_limit = 2000;

  logic                               clk;
  logic                               arst_n;
  noc_router_pkg::flit_t [nports-1:0] in_flit;
  logic                  [nports-1:0] in_valid;
  logic                  [nports-1:0] in_ready;
  noc_router_pkg::flit_t [nports-1:0] out_flit;
  logic                  [nports-1:0] out_valid;
  logic                  [nports-1:0] out_ready;
  logic                               bp_enable;
  logic                  [23:0]       lfsr;

  // Packet table from the golden file
  int                         pkt_test [max_pkts];
  int                         pkt_src [max_pkts];
  int                         pkt_out [max_pkts];
  int                         pkt_len [max_pkts];
  noc_router_pkg::flit_data_t pkt_hdr [max_pkts];
  noc_router_pkg::flit_data_t pkt_pay [max_pkts][max_pay];
  int                         num_pkts;

  int tests_passed;
  int tests_failed;
  int tb_errors;

  noc_router #(.ROUTER_X(4'd1), .ROUTER_Y(4'd1)) dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  noc_router_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  bind noc_router_output noc_router_asserts u_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .sw_flit   (sw_flit),
    .sw_req    (sw_req),
    .sw_ready  (sw_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^24 + x^23 + x^22 + x^17 + 1
  function automatic logic [23:0] lfsr_step(input logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Back-pressure, one LFSR step per ready bit
  ////////////////////////////////////////////////////////////
  initial begin
    lfsr      = 24'd80172;
    out_ready = '1;
    forever begin
      @(posedge clk);
      #1;
      if (bp_enable) begin
        for (int o = 0; o < nports; o++) begin
          lfsr         = lfsr_step(lfsr);
          out_ready[o] = lfsr[0];
        end
      end else begin
        out_ready = '1;
      end
    end
  end

  task automatic abort_run(input string reason);
    $display("run stopped: %s", reason);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  function automatic int assert_violations();
    return dut.g_output[0].u_output.u_asserts.violations
         + dut.g_output[1].u_output.u_asserts.violations
         + dut.g_output[2].u_output.u_asserts.violations
         + dut.g_output[3].u_output.u_asserts.violations
         + dut.g_output[4].u_output.u_asserts.violations;
  endfunction

  function automatic int error_total();
    return u_checker.error_count + tb_errors + assert_violations();
  endfunction

  task automatic load_golden();
    int         fd;
    int         fields;
    int         t, src, dx, dy, tag, out, len;
    logic [31:0] p [max_pay];
    string      line;
    fd = $fopen("bench/noc_router_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/noc_router_golden.txt");
    end else begin
      num_pkts = 0;
      while (!$feof(fd) && num_pkts < max_pkts) begin
        line = "";
        void'($fgets(line, fd));
        // Comment and blank lines skipped
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%d %d %h %h %h %d %d %h %h %h %h",
                         t, src, dx, dy, tag, out, len, p[0], p[1], p[2], p[3]);
        if (fields != 11) begin
          continue;
        end
        pkt_test[num_pkts] = t;
        pkt_src[num_pkts]  = src;
        pkt_out[num_pkts]  = out;
        pkt_len[num_pkts]  = len;
        // Free upper header bits carry test and packet number
        pkt_hdr[num_pkts]  = {8'(t), 8'(num_pkts), 8'(tag), 4'(dy), 4'(dx)};
        for (int k = 0; k < max_pay; k++) begin
          pkt_pay[num_pkts][k] = p[k];
        end
        num_pkts++;
      end
      $fclose(fd);
    end
  endtask

  // Flit k of packet n, header first
  function automatic noc_router_pkg::flit_t make_flit(input int n, input int k);
    noc_router_pkg::flit_t f;
    if (k == 0) begin
      f.data = pkt_hdr[n];
    end else begin
      f.data = pkt_pay[n][k-1];
    end
    f.last = (k == pkt_len[n]);
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus, called 1 ns after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic send_flit(input int port, input noc_router_pkg::flit_t flit);
    int cycles;
    in_flit[port]  = flit;
    in_valid[port] = 1'b1;
    cycles = 0;
    // in_ready is registered, stable here until the next edge
    while (!in_ready[port]) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > wait_limit) begin
        abort_run($sformatf("input %0d stuck with in_ready low", port));
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_port(input int t, input int port);
    for (int n = 0; n < num_pkts; n++) begin
      if (pkt_test[n] == t && pkt_src[n] == port) begin
        for (int k = 0; k <= pkt_len[n]; k++) begin
          send_flit(port, make_flit(n, k));
        end
      end
    end
    in_valid[port] = 1'b0;
  endtask

  task automatic wait_drained(input int t);
    int cycles;
    cycles = 0;
    while (u_checker.pending != 0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > drain_limit) begin
        u_checker.report_missing();
        abort_run($sformatf("test %0d timed out with %0d flits still expected",
                            t, u_checker.pending));
      end
    end
    // Last sampled transfer completes on the next edge
    repeat (2) begin
      @(posedge clk);
    end
    #1;
  endtask

  function automatic string test_name(input int t);
    case (t)
      2:       return "single-flit routing";
      3:       return "multi-flit packets";
      4:       return "output contention";
      5:       return "random back-pressure";
      default: return "other";
    endcase
  endfunction

  task automatic finish_test(input int t, input string name, input int errs_before);
    if (error_total() == errs_before) begin
      tests_passed++;
      $display("test %0d %s: pass", t, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", t, name, error_total() - errs_before);
    end
  endtask

  task automatic run_reset_test();
    int errs_before;
    int cycles;
    errs_before = error_total();
    u_checker.check_outputs_idle("right after reset");
    u_checker.check_in_ready('0, "first cycle after reset");
    cycles = 0;
    while (in_ready != '1) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 10) begin
        abort_run("in_ready did not rise after reset");
      end
    end
    u_checker.check_outputs_idle("once in_ready rose");
    finish_test(1, "reset state", errs_before);
  endtask

  task automatic run_packet_test(input int t);
    int errs_before;
    int low_before;
    errs_before = error_total();
    low_before  = u_checker.in_ready_low_cycles;
    // Expected flits queued before any can come out
    for (int n = 0; n < num_pkts; n++) begin
      if (pkt_test[n] == t) begin
        for (int k = 0; k <= pkt_len[n]; k++) begin
          u_checker.expect_flit(pkt_out[n],
                                pkt_hdr[n][noc_router_pkg::tag_msb:noc_router_pkg::tag_lsb],
                                make_flit(n, k));
        end
      end
    end
    bp_enable = (t == 5);
    fork
      send_port(t, noc_router_pkg::port_local);
      send_port(t, noc_router_pkg::port_north);
      send_port(t, noc_router_pkg::port_east);
      send_port(t, noc_router_pkg::port_south);
      send_port(t, noc_router_pkg::port_west);
    join
    wait_drained(t);
    bp_enable = 1'b0;
    if (t == 5 && u_checker.in_ready_low_cycles == low_before) begin
      tb_errors++;
      $display("in_ready never fell while all inputs were streaming");
    end
    finish_test(t, test_name(t), errs_before);
  endtask

  initial begin
    int errs_before;
    arst_n       = 1'b0;
    in_flit      = '0;
    in_valid     = '0;
    bp_enable    = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    tb_errors    = 0;
    load_golden();
    repeat (3) begin
      @(posedge clk);
    end
    #1;
    arst_n = 1'b1;
    run_reset_test();
    for (int t = 2; t <= 5; t++) begin
      run_packet_test(t);
    end
    // Nothing left queued or in flight
    errs_before = error_total();
    u_checker.report_missing();
    u_checker.check_outputs_idle("end of run");
    finish_test(6, "final state", errs_before);
    $display("closing counts: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_total() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: bench/noc_router_checker.sv
/*
  Scoreboard for the five router outputs, sampled on the falling edge.
  Expected flits are queued per output and per source tag, so tags must
  be unique per source port. Packets of one source keep their order,
  packets of different sources may arrive in any order.
*/
module noc_router_checker (
  input logic                                                 clk,
  input logic                                                 arst_n,
  input logic                  [noc_router_pkg::num_ports-1:0] in_ready,
  input noc_router_pkg::flit_t [noc_router_pkg::num_ports-1:0] out_flit,
  input logic                  [noc_router_pkg::num_ports-1:0] out_valid,
  input logic                  [noc_router_pkg::num_ports-1:0] out_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int nports = noc_router_pkg::num_ports;

  // Expected flits by output, then tag
  noc_router_pkg::flit_t exp_q [nports][256][$];
  bit                    in_pkt [nports] = '{default: 1'b0};
  bit [7:0]              cur_tag [nports] = '{default: 8'h00};

  int pending = 0;
  int error_count = 0;
  int in_ready_low_cycles = 0;

  // Every flit of a packet goes under the tag of its header
  task automatic expect_flit(input int port, input bit [7:0] tag,
                             input noc_router_pkg::flit_t flit);
    exp_q[port][tag].push_back(flit);
    pending++;
  endtask

  // One flit leaving an output
  task automatic check_flit(input int port, input noc_router_pkg::flit_t got);
    noc_router_pkg::flit_t exp;
    bit [7:0]              tag;
    // Header picks the queue for the rest of the packet
    if (!in_pkt[port]) begin
      cur_tag[port] = got.data[noc_router_pkg::tag_msb:noc_router_pkg::tag_lsb];
    end
    tag = cur_tag[port];
    if (exp_q[port][tag].size() == 0) begin
      error_count++;
      $display("unexpected %s at output %0d with tag %02h, data %08h",
               in_pkt[port] ? "flit" : "packet", port, tag, got.data);
    end else begin
      exp = exp_q[port][tag].pop_front();
      pending--;
      if (got !== exp) begin
        error_count++;
        $display("[FAIL] time %0d ns: output %0d tag %02h got %08h last %0b, expected %08h last %0b",
                 $time, port, tag, got.data, got.last, exp.data, exp.last);
      end
    end
    in_pkt[port] = !got.last;
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!arst_n) begin
      for (int o = 0; o < nports; o++) begin
        in_pkt[o] = 1'b0;
      end
    end else begin
      // Some FIFO full
      if (in_ready != '1) begin
        in_ready_low_cycles++;
      end
      for (int o = 0; o < nports; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          check_flit(o, out_flit[o]);
        end
      end
    end
  end

  task automatic check_outputs_idle(input string where);
    if (out_valid !== '0) begin
      error_count++;
      $display("[FAIL] time %0d ns: %s out_valid %05b, expected 00000", $time, where, out_valid);
    end
  endtask

  task automatic check_in_ready(input logic [nports-1:0] exp, input string where);
    if (in_ready !== exp) begin
      error_count++;
      $display("[FAIL] time %0d ns: %s in_ready %05b, expected %05b", $time, where, in_ready, exp);
    end
  endtask

  // Leftovers are packets that never came out
  task automatic report_missing();
    for (int o = 0; o < nports; o++) begin
      for (int t = 0; t < 256; t++) begin
        if (exp_q[o][t].size() != 0) begin
          error_count++;
          $display("%0d flits never arrived at output %0d for tag %02h", exp_q[o][t].size(), o, t);
        end
      end
    end
  endtask

endmodule

// File: bench/noc_router_asserts.sv
/*
  Handshake and wormhole rules of one output stage, bound to every
  instance of it. Checks are off while arst_n is low.
  The lock is tracked from grants and tail flits alone, without the
  arbiter's own state.
*/
module noc_router_asserts (
  input logic                                                 clk,
  input logic                                                 arst_n,
  input noc_router_pkg::flit_t [noc_router_pkg::num_ports-1:0] sw_flit,
  input noc_router_pkg::port_mask_t                           sw_req,
  input noc_router_pkg::port_mask_t                           sw_ready,
  input noc_router_pkg::flit_t                                out_flit,
  input logic                                                 out_valid,
  input logic                                                 out_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  int violations = 0;

  // Tail marker of every head flit
  noc_router_pkg::port_mask_t head_last;
  // Input holding this output mid-packet, zero when free
  noc_router_pkg::port_mask_t lock_mask;

  always_comb begin
    for (int i = 0; i < noc_router_pkg::num_ports; i++) begin
      head_last[i] = sw_flit[i].last;
    end
  end

  // Lock follows the grants, a tail flit frees it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lock_mask <= '0;
    end else if (sw_ready != '0) begin
      lock_mask <= ((sw_ready & head_last) != '0) ? '0 : sw_ready;
    end
  end

  // Stalled output flit held as is
  out_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_flit))
    else begin
      $error("output flit changed or dropped before its transfer");
      violations++;
    end

  // At most one input granted per cycle, and only a requesting one
  grant_onehot_a: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(sw_ready) && ((sw_ready & ~sw_req) == '0))
    else begin
      $error("sw_ready has more than one bit set or grants an idle input");
      violations++;
    end

  // Mid-packet output grants its owner only
  lock_owner_a: assert property (@(posedge clk) disable iff (!arst_n)
    lock_mask != '0 |-> (sw_ready & ~lock_mask) == '0)
    else begin
      $error("grant moved away from the owner of a locked output");
      violations++;
    end

endmodule

// File: source/noc_router.sv
/*
  Five-port mesh router, ports local, north, east, south, west.
  ROUTER_X and ROUTER_Y give this router's place in the mesh.
  Wormhole switching, one channel per port, per-flit valid/ready.
  Minimum latency is two edges from input accept to output valid.
*/
module noc_router #(
  parameter noc_router_pkg::coord_t ROUTER_X = 4'd1,
  parameter noc_router_pkg::coord_t ROUTER_Y = 4'd1
) (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  noc_router_pkg::flit_t [noc_router_pkg::num_ports-1:0] in_flit,
  input  logic                  [noc_router_pkg::num_ports-1:0] in_valid,
  output logic                  [noc_router_pkg::num_ports-1:0] in_ready,
  output noc_router_pkg::flit_t [noc_router_pkg::num_ports-1:0] out_flit,
  output logic                  [noc_router_pkg::num_ports-1:0] out_valid,
  input  logic                  [noc_router_pkg::num_ports-1:0] out_ready
);

  // Input side of the switch, indexed by input
  wire noc_router_pkg::flit_t      [noc_router_pkg::num_ports-1:0] sw_in_flit;
  wire noc_router_pkg::port_mask_t [noc_router_pkg::num_ports-1:0] sw_in_req;
  wire noc_router_pkg::port_mask_t [noc_router_pkg::num_ports-1:0] sw_in_ready;

  // Output side, indexed by output
  wire noc_router_pkg::port_mask_t [noc_router_pkg::num_ports-1:0] sw_out_req;
  wire noc_router_pkg::port_mask_t [noc_router_pkg::num_ports-1:0] sw_out_ready;

  for (genvar i = 0; i < noc_router_pkg::num_ports; i++) begin : g_input
    noc_router_input #(
      .ROUTER_X (ROUTER_X),
      .ROUTER_Y (ROUTER_Y)
    ) u_input (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_flit  (in_flit[i]),
      .in_valid (in_valid[i]),
      .in_ready (in_ready[i]),
      .sw_flit  (sw_in_flit[i]),
      .sw_req   (sw_in_req[i]),
      .sw_ready (sw_in_ready[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // Switch, transposed request and ready
  ////////////////////////////////////////////////////////////
  for (genvar o = 0; o < noc_router_pkg::num_ports; o++) begin : g_switch
    for (genvar i = 0; i < noc_router_pkg::num_ports; i++) begin : g_bit
      assign sw_out_req[o][i]  = sw_in_req[i][o];
      assign sw_in_ready[i][o] = sw_out_ready[o][i];
    end
  end

  // Every output sees all head flits
  for (genvar o = 0; o < noc_router_pkg::num_ports; o++) begin : g_output
    noc_router_output u_output (
      .clk       (clk),
      .arst_n    (arst_n),
      .sw_flit   (sw_in_flit),
      .sw_req    (sw_out_req[o]),
      .sw_ready  (sw_out_ready[o]),
      .out_flit  (out_flit[o]),
      .out_valid (out_valid[o]),
      .out_ready (out_ready[o])
    );
  end

endmodule

// File: source/noc_router_output.sv
/*
  Output stage of one router port.
  Round-robin among requesting inputs, starting at input 0 after reset.
  Locks to the winner until its last flit, so packets stay contiguous.
  One-entry output register; a grant loads it the same cycle.
  Requests must be held until the matching sw_ready bit is seen.
*/
module noc_router_output (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  noc_router_pkg::flit_t [noc_router_pkg::num_ports-1:0] sw_flit,
  input  noc_router_pkg::port_mask_t                           sw_req,
  output noc_router_pkg::port_mask_t                           sw_ready,
  output noc_router_pkg::flit_t                                out_flit,
  output logic                                                 out_valid,
  input  logic                                                 out_ready
);

  // Arbiter state
  noc_router_pkg::arb_state_t state;
  noc_router_pkg::port_idx_t  owner;
  noc_router_pkg::port_idx_t  rr_ptr;

  // Selection this cycle
  noc_router_pkg::port_idx_t  winner;
  noc_router_pkg::port_idx_t  sel;
  logic                       sel_valid;
  logic                       can_load;
  logic                       take;

  ////////////////////////////////////////////////////////////
  // Round-robin search
  ////////////////////////////////////////////////////////////
  // First requester at or after rr_ptr, circular
  always_comb begin
    int unsigned cand;
    logic        found;
    winner = rr_ptr;
    found  = 1'b0;
    for (int k = 0; k < noc_router_pkg::num_ports; k++) begin
      cand = (int'(rr_ptr) + k) % noc_router_pkg::num_ports;
      if (!found && sw_req[cand]) begin
        winner = noc_router_pkg::port_idx_t'(cand);
        found  = 1'b1;
      end
    end
  end

  // Locked output only listens to its owner
  always_comb begin
    if (state == noc_router_pkg::arb_locked) begin
      sel       = owner;
      sel_valid = sw_req[owner];
    end else begin
      sel       = winner;
      sel_valid = |sw_req;
    end
  end

  // Register empty or draining this cycle
  assign can_load = !out_valid || out_ready;
  assign take     = sel_valid && can_load;

  // Ready back to the granted input only
  assign sw_ready = take ? (noc_router_pkg::port_mask_t'(1) << sel) : '0;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (take) begin
      out_flit <= sw_flit[sel];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lock FSM and pointer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= noc_router_pkg::arb_idle;
      owner  <= '0;
      rr_ptr <= '0;
    end else if (take) begin
      // New packet start moves the pointer past the winner
      if (state == noc_router_pkg::arb_idle) begin
        if (sel == noc_router_pkg::port_idx_t'(noc_router_pkg::num_ports - 1)) begin
          rr_ptr <= '0;
        end else begin
          rr_ptr <= sel + 1'b1;
        end
      end
      if (sw_flit[sel].last) begin
        state <= noc_router_pkg::arb_idle;
      end else begin
        state <= noc_router_pkg::arb_locked;
        owner <= sel;
      end
    end
  end

endmodule

// File: source/noc_router_input.sv
/*
  Input stage of one router port.
  Buffers flits, routes each packet X first then Y from its header flit,
  and holds the route until the last flit has left.
  The header flit must carry destination x in bits 3..0 and y in 7..4.
  A packet never changes output once its header has been taken.
*/
module noc_router_input #(
  parameter noc_router_pkg::coord_t ROUTER_X = 4'd1,
  parameter noc_router_pkg::coord_t ROUTER_Y = 4'd1
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  noc_router_pkg::flit_t      in_flit,
  input  logic                       in_valid,
  output logic                       in_ready,
  output noc_router_pkg::flit_t      sw_flit,
  output noc_router_pkg::port_mask_t sw_req,
  input  noc_router_pkg::port_mask_t sw_ready
);

  // FIFO head
  noc_router_pkg::flit_t     head_flit;
  logic                      head_valid;
  logic                      head_pop;

  // Destination from the head flit
  noc_router_pkg::coord_t    dst_x;
  noc_router_pkg::coord_t    dst_y;

  // Route decode and held route
  noc_router_pkg::port_idx_t route_dec;
  noc_router_pkg::port_idx_t route_q;
  noc_router_pkg::port_idx_t route_sel;
  logic                      in_packet;

  ////////////////////////////////////////////////////////////
  // Flit buffer
  ////////////////////////////////////////////////////////////
  noc_router_fifo u_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_flit  (in_flit),
    .wr_valid (in_valid),
    .wr_ready (in_ready),
    .rd_flit  (head_flit),
    .rd_valid (head_valid),
    .rd_ready (head_pop)
  );

  ////////////////////////////////////////////////////////////
  // XY routing
  ////////////////////////////////////////////////////////////
  assign dst_x = head_flit.data[noc_router_pkg::dst_x_msb:noc_router_pkg::dst_x_lsb];
  assign dst_y = head_flit.data[noc_router_pkg::dst_y_msb:noc_router_pkg::dst_y_lsb];

  // X dimension resolved first
  always_comb begin
    if (dst_x > ROUTER_X) begin
      route_dec = noc_router_pkg::port_idx_t'(noc_router_pkg::port_east);
    end else if (dst_x < ROUTER_X) begin
      route_dec = noc_router_pkg::port_idx_t'(noc_router_pkg::port_west);
    end else if (dst_y > ROUTER_Y) begin
      route_dec = noc_router_pkg::port_idx_t'(noc_router_pkg::port_south);
    end else if (dst_y < ROUTER_Y) begin
      route_dec = noc_router_pkg::port_idx_t'(noc_router_pkg::port_north);
    end else begin
      route_dec = noc_router_pkg::port_idx_t'(noc_router_pkg::port_local);
    end
  end

  // Body flits follow the held route, header uses fresh decode
  assign route_sel = in_packet ? route_q : route_dec;

  ////////////////////////////////////////////////////////////
  // Switch side
  ////////////////////////////////////////////////////////////
  // Head flit goes to every output, only one request bit set
  assign sw_flit  = head_flit;
  assign sw_req   = head_valid ? (noc_router_pkg::port_mask_t'(1) << route_sel) : '0;

  // Addressed output took the flit this cycle
  assign head_pop = head_valid && sw_ready[route_sel];

  // Packet tracking
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_packet <= 1'b0;
      route_q   <= '0;
    end else if (head_pop) begin
      if (head_flit.last) begin
        in_packet <= 1'b0;
      end else begin
        in_packet <= 1'b1;
        route_q   <= route_sel;
      end
    end
  end

endmodule

// File: source/noc_router_fifo.sv
/*
  Input flit FIFO with valid/ready on both sides.
  Write ready is registered. It is low for one cycle after reset and
  afterwards low exactly while the FIFO is full.
  A write to a full FIFO is never accepted, even with a read that cycle.
*/
module noc_router_fifo (
  input  logic                  clk,
  input  logic                  arst_n,
  input  noc_router_pkg::flit_t wr_flit,
  input  logic                  wr_valid,
  output logic                  wr_ready,
  output noc_router_pkg::flit_t rd_flit,
  output logic                  rd_valid,
  input  logic                  rd_ready
);

  // Storage, payload only
  noc_router_pkg::flit_t mem [noc_router_pkg::fifo_depth];

  logic [noc_router_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [noc_router_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [noc_router_pkg::fifo_cnt_w-1:0] count;
  logic [noc_router_pkg::fifo_cnt_w-1:0] count_nxt;
  logic                                  push;
  logic                                  pop;

  // Circular increment, no power-of-two assumption
  function automatic logic [noc_router_pkg::fifo_ptr_w-1:0] ptr_inc(
    input logic [noc_router_pkg::fifo_ptr_w-1:0] ptr
  );
    if (ptr == noc_router_pkg::fifo_ptr_w'(noc_router_pkg::fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;
  assign rd_valid = (count != '0);
  assign rd_flit  = mem[rd_ptr];

  // Next fill level, push and pop together leave it unchanged
  always_comb begin
    count_nxt = count;
    if (push && !pop) begin
      count_nxt = count + 1'b1;
    end else if (pop && !push) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      wr_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count    <= count_nxt;
      // Ready for next cycle from next fill level
      wr_ready <= (count_nxt != noc_router_pkg::fifo_cnt_w'(noc_router_pkg::fifo_depth));
    end
  end

endmodule

// File: source/noc_router_pkg.sv
/*
  Shared widths, port numbering and types of the mesh router.
  One channel per port and no virtual channels.
  Header flit layout is fixed. Destination x and y are 4 bits each, so a
  mesh is at most 16 by 16. Bits above the source tag are free payload.
*/
package noc_router_pkg;

  // Flit and port geometry
  localparam int flit_w     = 32;
  localparam int num_ports  = 5;
  localparam int fifo_depth = 4;

  // Input FIFO pointer and fill count widths
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // Port numbering, also the switch index
  localparam int port_local = 0;
  localparam int port_north = 1;
  localparam int port_east  = 2;
  localparam int port_south = 3;
  localparam int port_west  = 4;

  localparam int coord_w = 4;

  ////////////////////////////////////////////////////////////
  // Header flit fields
  ////////////////////////////////////////////////////////////
  localparam int dst_x_lsb = 0;
  localparam int dst_x_msb = 3;
  localparam int dst_y_lsb = 4;
  localparam int dst_y_msb = 7;
  localparam int tag_lsb   = 8;
  localparam int tag_msb   = 15;

  typedef logic [flit_w-1:0]    flit_data_t;
  typedef logic [coord_w-1:0]   coord_t;
  typedef logic [num_ports-1:0] port_mask_t;
  typedef logic [2:0]           port_idx_t;

  // One flit on any link, last marks the packet tail
  typedef struct packed {
    flit_data_t data;
    logic       last;
  } flit_t;

  typedef enum logic {arb_idle, arb_locked} arb_state_t;

endpackage
